/* Makefile */
# Verilator build and run for the data cache testbench

SIM      = verilator
TOP      = tb_dcache
FILELIST = src.f
FLAGS    = --binary --assert -Wno-fatal -j 0 --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/data_store.sv */
/*
  line storage as a register array, one line_t per set and way
  reads are combinational, only strobed bytes change on a write
*/
`timescale 1ns/1ps

module data_store
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic [INDEX_W-1:0]    index_i,
    input  logic [WAY_W-1:0]      rd_way_i,
    input  logic                  wr_en_i,
    input  logic [WAY_W-1:0]      wr_way_i,
    input  line_t                 wr_line_i,
    input  logic [LINE_BYTES-1:0] wr_strb_i,
    output line_t                 rd_line_o
);

    line_t line_mem [WAYS][SETS];

    assign rd_line_o = line_mem[rd_way_i][index_i];

    // full strobe for refill, partial for a store hit
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (wr_strb_i[b]) begin
                    line_mem[wr_way_i][index_i].bytes[b] <= wr_line_i.bytes[b];
                end
            end
        end
    end

endmodule

/* hdl/dcache_pkg.sv */
/*
  geometry of the 4-way, 64-set, 16-byte-line data cache, fixed here
  line_t holds one cache line, seen as two bus beats or as sixteen bytes
*/
package dcache_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;   // cpu word and bus beat
    localparam int LINE_BYTES = 16;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 6;
    localparam int SETS       = 64;
    localparam int WAYS       = 4;
    localparam int WAY_W      = 2;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;   // 22

    // access size codes
    localparam logic [1:0] SIZE_B = 2'b00;   // 1 byte
    localparam logic [1:0] SIZE_H = 2'b01;   // 2 bytes
    localparam logic [1:0] SIZE_W = 2'b10;   // 4 bytes
    localparam logic [1:0] SIZE_D = 2'b11;   // 8 bytes

    // one line, beat 0 is the low half and goes first on the bus
    typedef union packed {
        logic [1:0][DATA_W-1:0]     beats;   // memory port view
        logic [LINE_BYTES-1:0][7:0] bytes;   // strobed merge view
    } line_t;

endpackage

/* hdl/dcache_top.sv */
/*
  write-back, write-allocate data cache, 4 ways x 64 sets x 16 B lines
  cpu holds its request until the cpu_ready_o pulse, one request in flight
*/
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // cpu side
    input  logic              cpu_valid_i,
    input  logic [ADDR_W-1:0] cpu_addr_i,
    input  logic              cpu_we_i,
    input  logic [1:0]        cpu_size_i,
    input  logic [DATA_W-1:0] cpu_wdata_i,
    output logic              cpu_ready_o,
    output logic [DATA_W-1:0] cpu_rdata_o,
    // memory read bus
    output logic              mem_rd_valid_o,
    output logic [ADDR_W-1:0] mem_rd_addr_o,
    input  logic              mem_rd_ready_i,
    input  logic [DATA_W-1:0] mem_rd_data_i,
    input  logic              mem_rd_last_i,
    // memory write bus
    output logic              mem_wr_valid_o,
    output logic [ADDR_W-1:0] mem_wr_addr_o,
    output logic [DATA_W-1:0] mem_wr_data_o,
    output logic              mem_wr_last_o,
    input  logic              mem_wr_ready_i,
    // counters
    output logic [31:0]       hit_count_o,
    output logic [31:0]       miss_count_o
);

    line_xfer_if xfer ();

    logic              accept, req_we, hit, victim_dirty;
    logic              fill, set_dirty, fill_dirty, line_sel, data_we, strb_sel;
    logic [ADDR_W-1:0] req_addr, victim_addr;
    logic [WAY_W-1:0]  hit_way, victim_way;
    logic [15:0]       req_strb;
    line_t             store_line, cap_line, wr_line;

    assign xfer.wr_line = store_line;                           // victim read out
    assign cap_line     = line_sel ? xfer.rd_line : store_line; // merge base

    req_capture u_req (
        .clk(clk), .rst(rst), .accept_i(accept),
        .cpu_addr_i(cpu_addr_i), .cpu_we_i(cpu_we_i),
        .cpu_size_i(cpu_size_i), .cpu_wdata_i(cpu_wdata_i),
        .rd_line_i(cap_line), .req_addr_o(req_addr), .req_we_o(req_we),
        .wr_line_o(wr_line), .wr_strb_o(req_strb), .rdata_o(cpu_rdata_o)
    );

    tag_store u_tags (
        .clk(clk), .rst(rst), .req_addr_i(req_addr),
        .fill_i(fill), .set_dirty_i(set_dirty), .fill_dirty_i(fill_dirty),
        .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way),
        .victim_dirty_o(victim_dirty), .victim_addr_o(victim_addr)
    );

    data_store u_data (
        .clk(clk), .index_i(req_addr[OFFSET_W +: INDEX_W]),
        .rd_way_i(hit_way), .wr_en_i(data_we), .wr_way_i(victim_way),
        .wr_line_i(wr_line), .wr_strb_i(strb_sel ? 16'hffff : req_strb),
        .rd_line_o(store_line)
    );

    miss_ctrl u_ctrl (
        .clk(clk), .rst(rst), .cpu_valid_i(cpu_valid_i), .hit_i(hit),
        .victim_dirty_i(victim_dirty), .victim_addr_i(victim_addr),
        .req_addr_i(req_addr), .req_we_i(req_we), .xfer(xfer.ctrl),
        .accept_o(accept), .cpu_ready_o(cpu_ready_o), .fill_o(fill),
        .set_dirty_o(set_dirty), .fill_dirty_o(fill_dirty),
        .line_sel_o(line_sel), .data_we_o(data_we), .strb_sel_o(strb_sel),
        .hit_count_o(hit_count_o), .miss_count_o(miss_count_o)
    );

    mem_port u_port (
        .clk(clk), .rst(rst), .xfer(xfer.port),
        .mem_rd_valid_o(mem_rd_valid_o), .mem_rd_addr_o(mem_rd_addr_o),
        .mem_rd_ready_i(mem_rd_ready_i), .mem_rd_data_i(mem_rd_data_i),
        .mem_rd_last_i(mem_rd_last_i),
        .mem_wr_valid_o(mem_wr_valid_o), .mem_wr_addr_o(mem_wr_addr_o),
        .mem_wr_data_o(mem_wr_data_o), .mem_wr_last_o(mem_wr_last_o),
        .mem_wr_ready_i(mem_wr_ready_i)
    );

endmodule

/* hdl/line_xfer_if.sv */
/*
  link from the cache FSM to the burst engine
  starts are single-cycle pulses, only while the port is idle
*/
`timescale 1ns/1ps

interface line_xfer_if
    import dcache_pkg::*;
();

    logic              rd_start;    // refill request
    logic              wr_start;    // write-back request
    logic [ADDR_W-1:0] xfer_addr;   // line aligned
    line_t             wr_line;     // victim line, sampled at wr_start
    line_t             rd_line;     // refilled line, good from done on
    logic              done;        // last beat transferred

    modport ctrl (
        output rd_start, wr_start, xfer_addr, wr_line,
        input  rd_line, done
    );

    modport port (
        input  rd_start, wr_start, xfer_addr, wr_line,
        output rd_line, done
    );

endinterface

/* hdl/mem_port.sv */
/*
  two-beat burst engine, one burst at a time, low beat first
  a read ends on mem_rd_last_i, a write after its second beat
*/
`timescale 1ns/1ps

module mem_port
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    line_xfer_if.port         xfer,
    // read bus
    output logic              mem_rd_valid_o,
    output logic [ADDR_W-1:0] mem_rd_addr_o,
    input  logic              mem_rd_ready_i,
    input  logic [DATA_W-1:0] mem_rd_data_i,
    input  logic              mem_rd_last_i,
    // write bus
    output logic              mem_wr_valid_o,
    output logic [ADDR_W-1:0] mem_wr_addr_o,
    output logic [DATA_W-1:0] mem_wr_data_o,
    output logic              mem_wr_last_o,
    input  logic              mem_wr_ready_i
);

    logic              beat_q;   // 0 low beat, 1 high beat
    logic [ADDR_W-1:0] addr_q;
    line_t             line_q;   // victim on write, refill on read
    logic              rd_fire;
    logic              wr_fire;

    assign rd_fire = mem_rd_valid_o & mem_rd_ready_i;
    assign wr_fire = mem_wr_valid_o & mem_wr_ready_i;

    assign mem_rd_addr_o = addr_q;
    assign mem_wr_addr_o = addr_q;
    assign mem_wr_data_o = line_q.beats[beat_q];
    assign mem_wr_last_o = beat_q;

    assign xfer.done    = (rd_fire & mem_rd_last_i) | (wr_fire & beat_q);
    assign xfer.rd_line = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_rd_valid_o <= 1'b0;
            mem_wr_valid_o <= 1'b0;
            beat_q         <= 1'b0;
        end else if (xfer.rd_start) begin
            mem_rd_valid_o <= 1'b1;
            beat_q         <= 1'b0;
        end else if (xfer.wr_start) begin
            mem_wr_valid_o <= 1'b1;
            beat_q         <= 1'b0;
        end else if (rd_fire) begin
            beat_q <= ~beat_q;
            if (mem_rd_last_i) mem_rd_valid_o <= 1'b0;
        end else if (wr_fire) begin
            beat_q <= ~beat_q;
            if (beat_q) mem_wr_valid_o <= 1'b0;   // high beat gone
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (xfer.rd_start || xfer.wr_start) begin
            addr_q <= xfer.xfer_addr;
        end
        if (xfer.wr_start) begin
            line_q <= xfer.wr_line;
        end else if (rd_fire) begin
            line_q.beats[beat_q] <= mem_rd_data_i;
        end
    end

endmodule

/* hdl/miss_ctrl.sv */
/*
  cache FSM: one request at a time, write-back strictly before refill
  a hit answers in LOOKUP, a miss answers in FILL
*/
`timescale 1ns/1ps

module miss_ctrl
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_valid_i,
    input  logic              hit_i,
    input  logic              victim_dirty_i,
    input  logic [ADDR_W-1:0] victim_addr_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic              req_we_i,
    line_xfer_if.ctrl         xfer,
    output logic              accept_o,
    output logic              cpu_ready_o,
    output logic              fill_o,
    output logic              set_dirty_o,
    output logic              fill_dirty_o,
    output logic              line_sel_o,    // 1: refilled line, 0: stored line
    output logic              data_we_o,
    output logic              strb_sel_o,    // 1: all bytes
    output logic [31:0]       hit_count_o,
    output logic [31:0]       miss_count_o
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        FILL
    } state_t;

    state_t state, state_nxt;
    logic   rd_issued_q;   // refill start already sent

    always_comb begin
        state_nxt     = state;
        accept_o      = 1'b0;
        cpu_ready_o   = 1'b0;
        fill_o        = 1'b0;
        set_dirty_o   = 1'b0;
        fill_dirty_o  = 1'b0;
        line_sel_o    = 1'b0;
        data_we_o     = 1'b0;
        strb_sel_o    = 1'b0;
        xfer.rd_start = 1'b0;
        xfer.wr_start = 1'b0;
        xfer.xfer_addr = {req_addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        case (state)
            IDLE: begin
                accept_o = cpu_valid_i;
                if (cpu_valid_i) state_nxt = LOOKUP;
            end
            LOOKUP: begin
                if (hit_i) begin
                    cpu_ready_o = 1'b1;
                    data_we_o   = req_we_i;   // partial write, store strobes
                    set_dirty_o = req_we_i;
                    state_nxt   = IDLE;
                end else if (victim_dirty_i) begin
                    xfer.wr_start  = 1'b1;
                    xfer.xfer_addr = victim_addr_i;
                    state_nxt      = WRITEBACK;
                end else begin
                    state_nxt = REFILL;
                end
            end
            WRITEBACK: begin
                if (xfer.done) state_nxt = REFILL;
            end
            REFILL: begin
                xfer.rd_start = ~rd_issued_q;   // port is idle again here
                if (xfer.done) state_nxt = FILL;
            end
            FILL: begin
                // refilled line with the store merged, written in one go
                fill_o       = 1'b1;
                fill_dirty_o = req_we_i;
                line_sel_o   = 1'b1;
                data_we_o    = 1'b1;
                strb_sel_o   = 1'b1;
                cpu_ready_o  = 1'b1;
                state_nxt    = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            rd_issued_q  <= 1'b0;
            hit_count_o  <= '0;
            miss_count_o <= '0;
        end else begin
            state <= state_nxt;
            if (xfer.rd_start) begin
                rd_issued_q <= 1'b1;
            end else if (state == FILL) begin
                rd_issued_q <= 1'b0;
            end
            if (state == LOOKUP) begin
                if (hit_i) hit_count_o <= hit_count_o + 1'b1;
                else miss_count_o <= miss_count_o + 1'b1;
            end
        end
    end

endmodule

/* hdl/req_capture.sv */
/*
  holds the one request in flight; store data is merged over rd_line_i
  so a refill and a store can be written as one line
*/
`timescale 1ns/1ps

module req_capture
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              accept_i,
    input  logic [ADDR_W-1:0] cpu_addr_i,
    input  logic              cpu_we_i,
    input  logic [1:0]        cpu_size_i,
    input  logic [DATA_W-1:0] cpu_wdata_i,
    input  line_t             rd_line_i,
    output logic [ADDR_W-1:0] req_addr_o,
    output logic              req_we_o,
    output line_t             wr_line_o,
    output logic [15:0]       wr_strb_o,
    output logic [DATA_W-1:0] rdata_o
);

    logic [1:0]        size_q;
    logic [DATA_W-1:0] wdata_q;
    logic [7:0]        lane_mask;   // bytes touched inside one beat
    logic [DATA_W-1:0] beat_data;   // store data moved to its lane
    line_t             store_line;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_addr_o <= '0;   // keeps tag lookup off after reset
            req_we_o   <= 1'b0;
        end else if (accept_i) begin
            req_addr_o <= cpu_addr_i;
            req_we_o   <= cpu_we_i;
        end
        if (accept_i) begin
            size_q  <= cpu_size_i;
            wdata_q <= cpu_wdata_i;
        end
    end

    always_comb begin
        case (size_q)
            SIZE_B:  lane_mask = 8'h01;
            SIZE_H:  lane_mask = 8'h03;
            SIZE_W:  lane_mask = 8'h0f;
            default: lane_mask = 8'hff;
        endcase
        // a read sets no strobe so the refilled line passes through whole
        lane_mask = req_we_o ? lane_mask << req_addr_o[2:0] : 8'h00;
        beat_data = wdata_q << (req_addr_o[2:0] * 8);
        // offset bit 3 picks the beat half
        wr_strb_o = req_addr_o[3] ? {lane_mask, 8'h00} : {8'h00, lane_mask};
        store_line.beats = {beat_data, beat_data};
        for (int i = 0; i < LINE_BYTES; i++) begin
            wr_line_o.bytes[i] = wr_strb_o[i] ? store_line.bytes[i] : rd_line_i.bytes[i];
        end
    end

    // selected beat shifted down to bit 0 for the read result
    assign rdata_o = rd_line_i.beats[req_addr_o[3]] >> (req_addr_o[2:0] * 8);

endmodule

/* hdl/tag_store.sv */
/*
  tags, valid and dirty bits for 64 sets x 4 ways, all ways compared at once
  on a miss hit_way_o and victim_way_o both fall back to the victim counter
*/
`timescale 1ns/1ps

module tag_store
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic              fill_i,         // install tag into victim way
    input  logic              set_dirty_i,    // store hit
    input  logic              fill_dirty_i,   // refill for a store
    output logic              hit_o,
    output logic [WAY_W-1:0]  hit_way_o,      // way the data store reads
    output logic [WAY_W-1:0]  victim_way_o,   // way the data store writes
    output logic              victim_dirty_o,
    output logic [ADDR_W-1:0] victim_addr_o
);

    logic [TAG_W-1:0]   tag_mem [SETS][WAYS];
    logic [WAYS-1:0]    valid_q [SETS];
    logic [WAYS-1:0]    dirty_q [SETS];
    logic [WAY_W-1:0]   victim_cnt;
    logic [WAY_W-1:0]   match_way;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;

    assign index = req_addr_i[OFFSET_W +: INDEX_W];
    assign tag   = req_addr_i[ADDR_W-1 -: TAG_W];

    always_comb begin
        hit_o     = 1'b0;
        match_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_q[index][w] && tag_mem[index][w] == tag) begin
                hit_o     = 1'b1;
                match_way = WAY_W'(w);
            end
        end
    end

    assign hit_way_o      = hit_o ? match_way : victim_cnt;
    assign victim_way_o   = hit_o ? match_way : victim_cnt;
    assign victim_dirty_o = valid_q[index][victim_cnt] & dirty_q[index][victim_cnt];
    assign victim_addr_o  = {tag_mem[index][victim_cnt], index, {OFFSET_W{1'b0}}};

    // the captured address misses for the whole miss, so freezing on
    // ~hit keeps the chosen way until the fill installs it
    always_ff @(posedge clk) begin
        if (rst) begin
            victim_cnt <= '0;
        end else if (hit_o) begin
            victim_cnt <= victim_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (fill_i) begin
            valid_q[index][victim_cnt] <= 1'b1;
            dirty_q[index][victim_cnt] <= fill_dirty_i;
        end else if (set_dirty_i && hit_o) begin
            dirty_q[index][match_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_mem[index][victim_cnt] <= tag;
        end
    end

endmodule

/* src.f */
hdl/dcache_pkg.sv
hdl/line_xfer_if.sv
hdl/req_capture.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/miss_ctrl.sv
hdl/mem_port.sv
hdl/dcache_top.sv
testbench/mem_model.sv
testbench/tb_dcache.sv

/* testbench/mem_model.sv */
/*
  8 KB memory responder for both bursts, addresses wrap at 8 KB
  ready drops at random, a beat moves on every cycle with valid and ready
*/
`timescale 1ns/1ps

module mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_rd_valid_i,
    input  logic [31:0] mem_rd_addr_i,
    output logic        mem_rd_ready_o,
    output logic [63:0] mem_rd_data_o,
    output logic        mem_rd_last_o,
    input  logic        mem_wr_valid_i,
    input  logic [31:0] mem_wr_addr_i,
    input  logic [63:0] mem_wr_data_i,
    output logic        mem_wr_ready_o
);

    localparam int MEM_BYTES = 8192;
    localparam int SEED      = 7407;

    logic [7:0] mem [MEM_BYTES];   // backing store, byte wide
    logic       rd_beat;           // beat that goes out next
    logic       wr_beat;

    initial begin
        void'($urandom(SEED));
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'(i) ^ {5'(i >> 8), 3'(i >> 10)} ^ 8'h5a;   // every address bit counts
        end
        rd_beat        = 1'b0;
        wr_beat        = 1'b0;
        mem_rd_ready_o = 1'b0;
        mem_wr_ready_o = 1'b0;
        mem_rd_data_o  = '0;
        mem_rd_last_o  = 1'b0;
        forever begin
            // handshakes are settled mid-cycle, the beat moves at the next edge
            @(negedge clk);
            if (rst) begin
                rd_beat = 1'b0;
                wr_beat = 1'b0;
            end else begin
                if (mem_wr_valid_i && mem_wr_ready_o) begin
                    for (int b = 0; b < 8; b++) begin
                        mem[{mem_wr_addr_i[12:4], wr_beat, 3'(b)}] = mem_wr_data_i[8*b +: 8];
                    end
                    wr_beat = ~wr_beat;
                end
                if (mem_rd_valid_i && mem_rd_ready_o) begin
                    rd_beat = ~rd_beat;
                end
            end
            @(posedge clk);
            #1;
            mem_rd_ready_o = ($urandom % 32'd4) != 32'd0;   // about one stall in four
            mem_wr_ready_o = ($urandom % 32'd4) != 32'd0;
            for (int b = 0; b < 8; b++) begin
                mem_rd_data_o[8*b +: 8] = mem[{mem_rd_addr_i[12:4], rd_beat, 3'(b)}];
            end
            mem_rd_last_o = rd_beat;   // high beat closes the burst
        end
    end

endmodule

/* testbench/tb_dcache.sv */
/*
  drives dcache_top through reads, stores and evictions against a shadow memory
  addresses stay below 8 KB, the size of the memory model
*/
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int MEM_BYTES  = 8192;
    localparam int N_REQS     = 85;             // 62 reads, 5 merge, 6 stores, 12 readback
    localparam int TIMEOUT    = 200 * N_REQS;   // cycles
    localparam int KIND_ANY   = 0;
    localparam int KIND_HIT   = 1;
    localparam int KIND_MISS  = 2;
    localparam logic [ADDR_W-1:0] EVICT_BASE = 32'h0c0;   // set 12, untouched before

    logic              clk = 1'b0;
    logic              rst;
    logic              cpu_valid_i;
    logic [ADDR_W-1:0] cpu_addr_i;
    logic              cpu_we_i;
    logic [1:0]        cpu_size_i;
    logic [DATA_W-1:0] cpu_wdata_i;
    logic              cpu_ready_o;
    logic [DATA_W-1:0] cpu_rdata_o;
    logic              mem_rd_valid_o, mem_rd_ready_i, mem_rd_last_i;
    logic [ADDR_W-1:0] mem_rd_addr_o;
    logic [DATA_W-1:0] mem_rd_data_i;
    logic              mem_wr_valid_o, mem_wr_last_o, mem_wr_ready_i;
    logic [ADDR_W-1:0] mem_wr_addr_o;
    logic [DATA_W-1:0] mem_wr_data_o;
    logic [31:0]       hit_count_o, miss_count_o;

    logic [7:0]        shadow [MEM_BYTES];   // what the cpu should see
    logic [ADDR_W-1:0] wb_addrs [$];         // write-back bursts seen
    logic [ADDR_W-1:0] line_addr;
    logic [ADDR_W-1:0] rd_addr_q, wr_addr_q;
    logic              started = 1'b0;       // first request issued
    logic              rd_end_q = 1'b0;
    logic              wr_end_q = 1'b0;
    int                rd_beats = 0;
    int                wr_beats = 0;
    int                cycle_cnt = 0;
    string             test_name = "reset";

    always #10 clk = ~clk;

    dcache_top DUT (
        .clk(clk), .rst(rst),
        .cpu_valid_i(cpu_valid_i), .cpu_addr_i(cpu_addr_i), .cpu_we_i(cpu_we_i),
        .cpu_size_i(cpu_size_i), .cpu_wdata_i(cpu_wdata_i),
        .cpu_ready_o(cpu_ready_o), .cpu_rdata_o(cpu_rdata_o),
        .mem_rd_valid_o(mem_rd_valid_o), .mem_rd_addr_o(mem_rd_addr_o),
        .mem_rd_ready_i(mem_rd_ready_i), .mem_rd_data_i(mem_rd_data_i),
        .mem_rd_last_i(mem_rd_last_i),
        .mem_wr_valid_o(mem_wr_valid_o), .mem_wr_addr_o(mem_wr_addr_o),
        .mem_wr_data_o(mem_wr_data_o), .mem_wr_last_o(mem_wr_last_o),
        .mem_wr_ready_i(mem_wr_ready_i),
        .hit_count_o(hit_count_o), .miss_count_o(miss_count_o)
    );

    mem_model u_mem (
        .clk(clk), .rst(rst),
        .mem_rd_valid_i(mem_rd_valid_o), .mem_rd_addr_i(mem_rd_addr_o),
        .mem_rd_ready_o(mem_rd_ready_i), .mem_rd_data_o(mem_rd_data_i),
        .mem_rd_last_o(mem_rd_last_i),
        .mem_wr_valid_i(mem_wr_valid_o), .mem_wr_addr_i(mem_wr_addr_o),
        .mem_wr_data_i(mem_wr_data_o), .mem_wr_ready_o(mem_wr_ready_i)
    );

    function automatic logic [7:0] fill_byte(input logic [12:0] a);
        return a[7:0] ^ {a[12:8], a[12:10]} ^ 8'h5a;   // preload of the memory model
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp)
            else abort_run($sformatf("Fail %s: %s expected %h, got %h",
                                     test_name, what, exp, act));
    endtask

    // one request, held until the ready pulse; cycles counts negedges from valid
    task automatic cpu_access(input logic we, input logic [1:0] size,
                              input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output int cycles);
        cpu_valid_i = 1'b1;
        cpu_addr_i  = addr;
        cpu_we_i    = we;
        cpu_size_i  = size;
        cpu_wdata_i = wdata;
        cycles      = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cpu_ready_o);
        rdata = cpu_rdata_o;   // only good in the ready cycle
        @(posedge clk);
        #1;
        cpu_valid_i = 1'b0;
    endtask

    task automatic run_req(input logic we, input logic [1:0] size,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                           input int kind);
        logic [DATA_W-1:0] rdata;
        logic [DATA_W-1:0] expected;
        logic [DATA_W-1:0] mask;
        logic [12:0]       a;
        logic [31:0]       hits0;
        logic [31:0]       misses0;
        int                cycles;
        int                n;
        n        = 1 << size;
        hits0    = hit_count_o;
        misses0  = miss_count_o;
        expected = '0;
        started  = 1'b1;
        cpu_access(we, size, addr, wdata, rdata, cycles);
        mask = (n == 8) ? '1 : (64'd1 << (8 * n)) - 64'd1;   // bytes above size are don't care
        for (int i = 0; i < n; i++) begin
            a = addr[12:0] + 13'(i);
            if (we) begin
                shadow[a] = wdata[8*i +: 8];   // little endian, low bytes of wdata
            end else begin
                expected[8*i +: 8] = shadow[a];
            end
        end
        if (!we) begin
            check_value($sformatf("read at %h", addr), expected, rdata & mask);
        end
        // counters move on the edge closing LOOKUP, already behind us
        case (kind)
            KIND_HIT: begin
                check_value("hit latency", 64'd2, 64'(cycles));   // capture + lookup
                check_value("hit count", 64'(hits0 + 32'd1), 64'(hit_count_o));
                check_value("miss count", 64'(misses0), 64'(miss_count_o));
            end
            KIND_MISS: begin
                check_value("miss count", 64'(misses0 + 32'd1), 64'(miss_count_o));
                check_value("hit count", 64'(hits0), 64'(hit_count_o));
            end
            default: begin
                check_value("access count", 64'(hits0 + misses0 + 32'd1),
                            64'(hit_count_o + miss_count_o));
            end
        endcase
    endtask

    // victim way is unknown, so only lines that were written back are compared
    task automatic check_evicted();
        logic [12:0] a;
        assert (wb_addrs.size() >= 2)
            else abort_run("six stores into one 4-way set gave fewer than two write-backs");
        foreach (wb_addrs[i]) begin
            check_value("write-back set", 64'(EVICT_BASE[9:4]), 64'(wb_addrs[i][9:4]));
            for (int b = 0; b < LINE_BYTES; b++) begin
                a = wb_addrs[i][12:0] + 13'(b);
                check_value($sformatf("memory byte %h", a), 64'(shadow[a]), 64'(u_mem.mem[a]));
            end
        end
    endtask

    // bus protocol, sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        if (!rst) begin
            if (!started) begin
                assert (!cpu_ready_o && !mem_rd_valid_o && !mem_wr_valid_o)
                    else abort_run("ready or a bus valid went high before the first request");
            end
            if (rd_end_q) begin
                assert (!mem_rd_valid_o) else abort_run("read valid held after the last beat");
            end
            if (wr_end_q) begin
                assert (!mem_wr_valid_o) else abort_run("write valid held after the last beat");
            end
            rd_end_q = 1'b0;
            wr_end_q = 1'b0;
            if (mem_rd_valid_o && mem_rd_ready_i) begin
                rd_beats++;
                assert (mem_rd_addr_o[3:0] == 4'h0)
                    else abort_run("read burst address is not line aligned");
                if (rd_beats == 1) begin
                    rd_addr_q = mem_rd_addr_o;
                end
                assert (mem_rd_addr_o == rd_addr_q)
                    else abort_run("read address changed inside a burst");
                assert (mem_rd_last_i == (rd_beats == 2))
                    else abort_run("read burst last flag not on its second beat");
                if (mem_rd_last_i) begin
                    rd_beats = 0;
                    rd_end_q = 1'b1;
                end
            end
            if (mem_wr_valid_o && mem_wr_ready_i) begin
                wr_beats++;
                assert (mem_wr_addr_o[3:0] == 4'h0)
                    else abort_run("write burst address is not line aligned");
                if (wr_beats == 1) begin
                    wr_addr_q = mem_wr_addr_o;
                end
                assert (mem_wr_addr_o == wr_addr_q)
                    else abort_run("write address changed inside a burst");
                assert (mem_wr_last_o == (wr_beats == 2))
                    else abort_run("write burst last flag not on its second beat");
                if (mem_wr_last_o) begin
                    wb_addrs.push_back(mem_wr_addr_o);
                    wr_beats = 0;
                    wr_end_q = 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            abort_run($sformatf("timeout, run not finished after %0d cycles", TIMEOUT));
        end
    end

    initial begin
        rst         = 1'b1;
        cpu_valid_i = 1'b0;
        cpu_addr_i  = '0;
        cpu_we_i    = 1'b0;
        cpu_size_i  = SIZE_B;
        cpu_wdata_i = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[i] = fill_byte(13'(i));
        end
        repeat (8) @(posedge clk);
        #1;
        rst       = 1'b0;
        test_name = "reset_idle";
        repeat (5) @(posedge clk);   // outputs must stay quiet here
        #1;

        // every size and offset, refill then hits in the same line
        test_name = "read_sizes";
        for (int l = 0; l < 2; l++) begin
            line_addr = (l == 0) ? 32'h100 : 32'h2a0;
            run_req(1'b0, SIZE_D, line_addr + 32'h8, '0, KIND_MISS);
            for (int s = 0; s < 4; s++) begin
                for (int off = 0; off < LINE_BYTES; off += (1 << s)) begin
                    run_req(1'b0, 2'(s), line_addr + 32'(off), '0, KIND_HIT);
                end
            end
        end

        // garbage above the access size must not reach the line
        test_name = "store_merge";
        run_req(1'b1, SIZE_B, 32'h345, 64'hdead_beef_cafe_00a7, KIND_MISS);
        run_req(1'b1, SIZE_H, 32'h34a, 64'h5555_5555_5555_beef, KIND_HIT);
        run_req(1'b1, SIZE_W, 32'h340, 64'haaaa_aaaa_1234_5678, KIND_HIT);
        run_req(1'b0, SIZE_D, 32'h340, '0, KIND_HIT);
        run_req(1'b0, SIZE_D, 32'h348, '0, KIND_HIT);

        // six lines, one set, four ways
        test_name = "evict";
        wb_addrs.delete();
        for (int k = 0; k < 6; k++) begin
            run_req(1'b1, SIZE_D, EVICT_BASE + 32'(k * 32'h400) + 32'h8,
                    64'h0123_4567_89ab_cdef + 64'(k), KIND_MISS);
        end
        check_evicted();

        test_name = "evict_readback";
        for (int k = 0; k < 6; k++) begin
            run_req(1'b0, SIZE_D, EVICT_BASE + 32'(k * 32'h400), '0, KIND_ANY);
            run_req(1'b0, SIZE_D, EVICT_BASE + 32'(k * 32'h400) + 32'h8, '0, KIND_ANY);
        end

        $display("No errors");
        $finish;
    end

endmodule
